//--- Bender.yml
package:
  name: fft_stage

sources:
  - src/fft_stage_pkg.sv
  - src/slot_counter.sv
  - src/stage_ctrl.sv
  - src/butterfly.sv
  - src/butterfly_lane.sv
  - src/fft_stage_top.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_fft_stage.sv

//--- compile.f
+incdir+sim
src/fft_stage_pkg.sv
src/slot_counter.sv
src/stage_ctrl.sv
src/butterfly.sv
src/butterfly_lane.sv
src/fft_stage_top.sv
sim/tb_fft_stage.sv

//--- sim/tb_ref_model.svh
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// Butterfly rule in plain integer arithmetic
function automatic void butterfly_model(
        input fft_stage_pkg::cplx_t a,
        input fft_stage_pkg::cplx_t b,
        input fft_stage_pkg::cplx_t w,
        output fft_stage_pkg::cplx_t sum,
        output fft_stage_pkg::cplx_t diff
);
        longint p_re;
        longint p_im;
        longint t;

        p_re = (longint'(w.re) * longint'(b.re) - longint'(w.im) * longint'(b.im))
                >>> fft_stage_pkg::frac_w;
        p_im = (longint'(w.re) * longint'(b.im) + longint'(w.im) * longint'(b.re))
                >>> fft_stage_pkg::frac_w;

        // Halved, then cut back to one part
        t = (longint'(a.re) + p_re) >>> 1;
        sum.re = t[fft_stage_pkg::sample_w-1:0];
        t = (longint'(a.im) + p_im) >>> 1;
        sum.im = t[fft_stage_pkg::sample_w-1:0];
        t = (longint'(a.re) - p_re) >>> 1;
        diff.re = t[fft_stage_pkg::sample_w-1:0];
        t = (longint'(a.im) - p_im) >>> 1;
        diff.im = t[fft_stage_pkg::sample_w-1:0];
endfunction

function automatic fft_stage_pkg::frame_t stage_model(input fft_stage_pkg::frame_t x);
        fft_stage_pkg::frame_t y;
        fft_stage_pkg::cplx_t s;
        fft_stage_pkg::cplx_t d;
        int base;

        y = '0;
        for (int g = 0; g < fft_stage_pkg::n_points / (2 * fft_stage_pkg::span); g++)
        begin
                base = 2 * fft_stage_pkg::span * g;
                // Sample n pairs with n+8 under twiddle k = n mod 8
                for (int k = 0; k < fft_stage_pkg::span; k++)
                begin
                        butterfly_model(x[base + k], x[base + k + fft_stage_pkg::span],
                                fft_stage_pkg::twiddle[k], s, d);
                        y[base + k] = s;
                        y[base + k + fft_stage_pkg::span] = d;
                end
        end
        return y;
endfunction

`endif

//--- sim/tb_fft_stage.sv
`timescale 1ns/1ns

module tb_fft_stage;

        localparam int reset_cycles = 10;
        localparam int done_timeout = 50;
        localparam int n_random = 20;
        localparam int hold_cycles = 8;

        logic clk;
        logic reset;
        logic start;
        fft_stage_pkg::frame_t frame_in;
        logic busy;
        logic done;
        fft_stage_pkg::frame_t frame_out;

        integer seed;

        `include "tb_ref_model.svh"

        fft_stage_top i_dut
        (
                .clk       (clk),
                .reset     (reset),
                .start     (start),
                .frame_in  (frame_in),
                .busy      (busy),
                .done      (done),
                .frame_out (frame_out)
        );

        initial
        begin
                clk = 1'b0;
                forever
                begin
                        #5 clk = ~clk;
                end
        end

        task automatic stop_with_failure(input string what);
                $display("%s", what);
                $display("Test FAILED");
                $fatal(1, "stopped at the first error");
        endtask

        task automatic check_value(input string test, input logic [63:0] expected,
                input logic [63:0] actual);
                if (expected !== actual)
                begin
                        stop_with_failure($sformatf("mismatch in %s: expected %h, actual %h",
                                test, expected, actual));
                end
        endtask

        task automatic check_frame(input string test, input fft_stage_pkg::frame_t expected);
                for (int n = 0; n < fft_stage_pkg::n_points; n++)
                begin
                        check_value($sformatf("%s, sample %0d", test, n), expected[n], frame_out[n]);
                end
        endtask

        // Parts kept within +-1.0 in Q1.14
        function automatic fft_stage_pkg::frame_t random_frame();
                fft_stage_pkg::frame_t x;
                logic [31:0] r;

                for (int n = 0; n < fft_stage_pkg::n_points; n++)
                begin
                        r = $random(seed);
                        x[n].re = $signed(r[31:16]) >>> 1;
                        x[n].im = $signed(r[15:0]) >>> 1;
                end
                return x;
        endfunction

        // Returns on the edge where the controller samples start
        task automatic send_start(input fft_stage_pkg::frame_t x);
                @(posedge clk);
                frame_in <= x;
                start <= 1'b1;
                @(posedge clk);
                start <= 1'b0;
        endtask

        task automatic wait_for_done(input string test, output int cycles,
                output logic busy_held);
                logic done_seen;

                cycles = 0;
                busy_held = 1'b1;
                done_seen = 1'b0;
                while (!done_seen && cycles < done_timeout)
                begin
                        @(negedge clk);
                        cycles++;
                        if (done)
                                done_seen = 1'b1;
                        else if (!busy)
                                busy_held = 1'b0;
                end
                if (!done_seen)
                begin
                        stop_with_failure($sformatf("done never came within %0d cycles in %s",
                                done_timeout, test));
                end
        endtask

        task automatic test_reset();
                check_value("reset busy", 1'b0, busy);
                check_value("reset done", 1'b0, done);
                check_frame("reset frame_out", '0);
        endtask

        task automatic test_zero_twiddle();
                fft_stage_pkg::frame_t x;
                fft_stage_pkg::frame_t expected;
                fft_stage_pkg::cplx_t a;
                fft_stage_pkg::cplx_t b;
                int cycles;
                logic busy_held;

                // Odd sums exercise the floor of the halving
                a.re = 16'sd6000;
                a.im = -16'sd2500;
                b.re = 16'sd3000;
                b.im = 16'sd7001;
                x = '0;
                x[0] = a;
                x[fft_stage_pkg::span] = b;
                expected = '0;
                expected[0].re = (int'(a.re) + int'(b.re)) >>> 1;
                expected[0].im = (int'(a.im) + int'(b.im)) >>> 1;
                expected[fft_stage_pkg::span].re = (int'(a.re) - int'(b.re)) >>> 1;
                expected[fft_stage_pkg::span].im = (int'(a.im) - int'(b.im)) >>> 1;
                send_start(x);
                wait_for_done("zero twiddle", cycles, busy_held);
                check_frame("zero twiddle", expected);
        endtask

        task automatic test_twiddle_path();
                fft_stage_pkg::frame_t x;
                fft_stage_pkg::frame_t expected;
                fft_stage_pkg::cplx_t w;
                int base;
                int cycles;
                logic busy_held;

                x = '0;
                expected = '0;
                for (int g = 0; g < 2; g++)
                begin
                        base = 2 * fft_stage_pkg::span * g;
                        for (int k = 0; k < fft_stage_pkg::span; k++)
                        begin
                                w = fft_stage_pkg::twiddle[k];
                                x[base + fft_stage_pkg::span + k].re = 16'sd16384;
                                expected[base + k].re = int'(w.re) >>> 1;
                                expected[base + k].im = int'(w.im) >>> 1;
                                expected[base + fft_stage_pkg::span + k].re = (-int'(w.re)) >>> 1;
                                expected[base + fft_stage_pkg::span + k].im = (-int'(w.im)) >>> 1;
                        end
                end
                send_start(x);
                wait_for_done("twiddle path", cycles, busy_held);
                check_frame("twiddle path", expected);
        endtask

        task automatic test_random_frames();
                fft_stage_pkg::frame_t x;
                string name;
                int cycles;
                logic busy_held;

                for (int i = 0; i < n_random; i++)
                begin
                        name = $sformatf("random frame %0d", i);
                        x = random_frame();
                        send_start(x);
                        wait_for_done(name, cycles, busy_held);
                        // done follows the fourth edge after start
                        check_value({name, " latency"}, fft_stage_pkg::n_slots + 1, cycles);
                        check_value({name, " busy held"}, 1'b1, busy_held);
                        check_frame(name, stage_model(x));
                end
        endtask

        task automatic test_ignored_restart();
                fft_stage_pkg::frame_t x1;
                fft_stage_pkg::frame_t x2;
                int cycles;
                logic busy_held;

                x1 = random_frame();
                x2 = random_frame();
                send_start(x1);
                @(posedge clk);
                start <= 1'b1;
                @(posedge clk);
                start <= 1'b0;
                wait_for_done("ignored restart", cycles, busy_held);
                check_value("ignored restart busy held", 1'b1, busy_held);
                @(posedge clk);
                frame_in <= x2;
                // No second frame may follow
                repeat (2 * fft_stage_pkg::n_slots)
                begin
                        @(negedge clk);
                        check_value("ignored restart extra done", 1'b0, done);
                        check_value("ignored restart extra busy", 1'b0, busy);
                end
                @(posedge clk);
                frame_in <= x1;
                @(negedge clk);
                check_frame("ignored restart", stage_model(x1));
        endtask

        task automatic test_hold();
                fft_stage_pkg::frame_t x1;
                fft_stage_pkg::frame_t x2;
                int cycles;
                logic busy_held;

                x1 = random_frame();
                x2 = random_frame();
                send_start(x1);
                wait_for_done("hold", cycles, busy_held);
                // A new frame on the input must not reach the idle lanes
                @(posedge clk);
                frame_in <= x2;
                repeat (hold_cycles)
                begin
                        @(negedge clk);
                        check_value("hold done", 1'b0, done);
                        check_frame("hold idle", stage_model(x1));
                end
                send_start(x2);
                @(negedge clk);
                check_frame("hold before first slot write", stage_model(x1));
                wait_for_done("hold next frame", cycles, busy_held);
                check_frame("hold next frame", stage_model(x2));
        endtask

        initial
        begin
                seed = 73;
                reset = 1'b1;
                start = 1'b0;
                frame_in = '0;
                repeat (reset_cycles) @(posedge clk);
                reset <= 1'b0;
                @(negedge clk);
                test_reset();
                test_zero_twiddle();
                test_twiddle_path();
                test_random_frames();
                test_ignored_restart();
                test_hold();
                $display("Test OK");
                $finish;
        end

endmodule

//--- src/butterfly.sv
`timescale 1ns/1ns

module butterfly
(
        input  fft_stage_pkg::cplx_t a,
        input  fft_stage_pkg::cplx_t b,
        input  fft_stage_pkg::cplx_t w,
        output fft_stage_pkg::cplx_t sum,
        output fft_stage_pkg::cplx_t diff
);

        // Cross sum of two 16x16 products needs one extra bit
        localparam int prod_w = 2 * fft_stage_pkg::sample_w + 1;
        localparam int p_w = prod_w - fft_stage_pkg::frac_w;
        localparam int acc_w = p_w + 1;

        logic signed [prod_w-1:0] p_re_full;
        logic signed [prod_w-1:0] p_im_full;
        logic signed [p_w-1:0] p_re;
        logic signed [p_w-1:0] p_im;
        logic signed [acc_w-1:0] sum_re;
        logic signed [acc_w-1:0] sum_im;
        logic signed [acc_w-1:0] diff_re;
        logic signed [acc_w-1:0] diff_im;

        always_comb
        begin
                p_re_full = w.re * b.re - w.im * b.im;
                p_im_full = w.re * b.im + w.im * b.re;

                // Drop the fraction bits of the twiddle
                p_re = p_re_full[prod_w-1:fft_stage_pkg::frac_w];
                p_im = p_im_full[prod_w-1:fft_stage_pkg::frac_w];

                sum_re = a.re + p_re;
                sum_im = a.im + p_im;
                diff_re = a.re - p_re;
                diff_im = a.im - p_im;

                // Halve on the way out so the result fits Q1.14 again
                sum.re = sum_re[fft_stage_pkg::sample_w:1];
                sum.im = sum_im[fft_stage_pkg::sample_w:1];
                diff.re = diff_re[fft_stage_pkg::sample_w:1];
                diff.im = diff_im[fft_stage_pkg::sample_w:1];
        end

endmodule

//--- src/butterfly_lane.sv
`timescale 1ns/1ns

module butterfly_lane
#(
        parameter int lane = 0
)
(
        input  logic clk,
        input  logic reset,
        input  logic busy,
        input  fft_stage_pkg::slot_t slot,
        input  fft_stage_pkg::frame_t frame_in,
        output fft_stage_pkg::cplx_t [2*fft_stage_pkg::span-1:0] results
);

        localparam int lanes_per_block = fft_stage_pkg::span / fft_stage_pkg::n_slots;
        localparam int g = lane / lanes_per_block;
        localparam int h = lane % lanes_per_block;
        localparam int base = g * 2 * fft_stage_pkg::span;
        localparam int k_w = $clog2(fft_stage_pkg::span);

        typedef logic [k_w-1:0] tw_idx_t;

        // First twiddle index this lane owns
        localparam tw_idx_t k_base = tw_idx_t'(h * fft_stage_pkg::n_slots);

        tw_idx_t k;
        fft_stage_pkg::cplx_t op_a;
        fft_stage_pkg::cplx_t op_b;
        fft_stage_pkg::cplx_t op_w;
        fft_stage_pkg::cplx_t bf_sum;
        fft_stage_pkg::cplx_t bf_diff;

        assign k = k_base + tw_idx_t'(slot);

        // Pair n with n+8 inside the block
        always_comb
        begin
                op_a = frame_in[base + k];
                op_b = frame_in[base + fft_stage_pkg::span + k];
                op_w = fft_stage_pkg::twiddle[k];
        end

        butterfly i_butterfly
        (
                .a    (op_a),
                .b    (op_b),
                .w    (op_w),
                .sum  (bf_sum),
                .diff (bf_diff)
        );

        always_ff @(posedge clk)
        begin
                if (reset)
                begin
                        results <= '0;
                end
                else if (busy)
                begin
                        // Every slot writes, zero results included
                        results[k] <= bf_sum;
                        results[fft_stage_pkg::span + k] <= bf_diff;
                end
        end

endmodule

//--- src/fft_stage_pkg.sv
package fft_stage_pkg;

        // Frame geometry of the third stage
        localparam int n_points = 32;
        localparam int span = 8;
        localparam int n_lanes = 4;
        localparam int n_slots = 4;

        // Q1.14 parts
        localparam int sample_w = 16;
        localparam int frac_w = 14;

        typedef logic [1:0] slot_t;

        typedef struct packed {
                logic signed [sample_w-1:0] re;
                logic signed [sample_w-1:0] im;
        } cplx_t;

        // Sample 0 sits in the low word
        typedef cplx_t [n_points-1:0] frame_t;

        // W16^k for k = 0..7, scaled by 2^14
        localparam cplx_t twiddle [span] = '{
                '{re: 16'sd16384, im: 16'sd0},
                '{re: 16'sd15137, im: -16'sd6270},
                '{re: 16'sd11585, im: -16'sd11585},
                '{re: 16'sd6270, im: -16'sd15137},
                '{re: 16'sd0, im: -16'sd16384},
                '{re: -16'sd6270, im: -16'sd15137},
                '{re: -16'sd11585, im: -16'sd11585},
                '{re: -16'sd15137, im: -16'sd6270}
        };

endpackage

//--- src/fft_stage_top.sv
`timescale 1ns/1ns

module fft_stage_top
(
        input  logic clk,
        input  logic reset,
        input  logic start,
        input  fft_stage_pkg::frame_t frame_in,
        output logic busy,
        output logic done,
        output fft_stage_pkg::frame_t frame_out
);

        localparam int block_len = 2 * fft_stage_pkg::span;
        localparam int lanes_per_block = fft_stage_pkg::span / fft_stage_pkg::n_slots;

        fft_stage_pkg::slot_t slot;
        logic last;
        fft_stage_pkg::cplx_t [block_len-1:0] lane_results [fft_stage_pkg::n_lanes];

        stage_ctrl i_stage_ctrl
        (
                .clk   (clk),
                .reset (reset),
                .start (start),
                .last  (last),
                .busy  (busy),
                .done  (done)
        );

        slot_counter i_slot_counter
        (
                .clk   (clk),
                .reset (reset),
                .busy  (busy),
                .slot  (slot),
                .last  (last)
        );

        for (genvar i = 0; i < fft_stage_pkg::n_lanes; i++)
        begin : g_lane
                butterfly_lane #(.lane(i)) i_lane
                (
                        .clk      (clk),
                        .reset    (reset),
                        .busy     (busy),
                        .slot     (slot),
                        .frame_in (frame_in),
                        .results  (lane_results[i])
                );
        end

        // Index 16g+j is owned by the lane of block g that covers j mod 8
        always_comb
        begin
                for (int n = 0; n < fft_stage_pkg::n_points; n++)
                begin
                        frame_out[n] = lane_results[(n / block_len) * lanes_per_block
                                + (n % fft_stage_pkg::span) / fft_stage_pkg::n_slots]
                                [n % block_len];
                end
        end

endmodule

//--- src/slot_counter.sv
`timescale 1ns/1ns

module slot_counter
(
        input  logic clk,
        input  logic reset,
        input  logic busy,
        output fft_stage_pkg::slot_t slot,
        output logic last
);

        always_ff @(posedge clk)
        begin
                if (reset)
                begin
                        slot <= '0;
                end
                else if (busy)
                begin
                        // Wraps to 0 after the final slot
                        slot <= slot + fft_stage_pkg::slot_t'(1);
                end
        end

        assign last = (slot == fft_stage_pkg::slot_t'(fft_stage_pkg::n_slots - 1));

        // Slot rests at 0 between frames
        a_slot_idle_zero: assert property (
                @(posedge clk) disable iff (reset)
                !busy |-> (slot == '0)
        );

endmodule

//--- src/stage_ctrl.sv
`timescale 1ns/1ns

module stage_ctrl
(
        input  logic clk,
        input  logic reset,
        input  logic start,
        input  logic last,
        output logic busy,
        output logic done
);

        typedef enum logic {
                st_idle,
                st_run
        } state_t;

        state_t state;
        state_t state_next;

        always_comb
        begin
                state_next = state;
                case (state)
                        st_idle:
                        begin
                                if (start)
                                        state_next = st_run;
                        end
                        st_run:
                        begin
                                // start is ignored here
                                if (last)
                                        state_next = st_idle;
                        end
                        default:
                        begin
                                state_next = st_idle;
                        end
                endcase
        end

        always_ff @(posedge clk)
        begin
                if (reset)
                begin
                        state <= st_idle;
                        done <= 1'b0;
                end
                else
                begin
                        state <= state_next;
                        done <= (state == st_run) && last;
                end
        end

        assign busy = (state == st_run);

        // One single-cycle done per frame, n_slots cycles after busy rises
        a_done_single: assert property (
                @(posedge clk) disable iff (reset)
                $rose(busy) |-> ##(fft_stage_pkg::n_slots) done ##1 !done
        );

        // Done only comes after the frame has left the lanes
        a_done_not_busy: assert property (
                @(posedge clk) disable iff (reset)
                !(done && busy)
        );

endmodule
